// File: run_sim.sh
#!/usr/bin/env bash
# Build with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module sdram_tb \
   -Mdir obj_dir -o sdram_sim > build.log 2>&1 &&
   ./obj_dir/sdram_sim +verilator+error+limit+1000 > sim.log 2>&1
grep -q '^\*\* PASS \*\*$' sim.log 2>/dev/null && echo "Simulation passed" ||
   { echo "Simulation failed, see build.log and sim.log"; exit 1; }

// File: source/sdram_cmd_seq.sv
/* Command FSM for one device, one request in flight, closed page.
   Timing fields must be at least 1; cas up to 7. Refresh wins in idle.
   Pins are registered; DQM and write data follow the beat register. */
`timescale 1ns/1ps

module sdram_cmd_seq (
   input  logic                          clk,
   input  logic                          reset,
   input  sdram_pkg::sdram_timing_t      timing,
   input  logic                          init_start,
   input  logic                          refresh_due,
   input  logic                          req_valid,
   input  logic                          req_write,
   input  sdram_pkg::beat_addr_t         beat_addr,
   input  logic [sdram_pkg::SDR_DW-1:0]  wr_data,
   input  logic [sdram_pkg::SDR_BW-1:0]  wr_dqm,
   output logic                          refresh_ack,
   output logic                          take_req,
   output logic                          wr_beat,
   output logic                          rd_beat,
   output logic                          init_done,
   output sdram_pkg::sdram_pins_t        pins,
   output logic [sdram_pkg::SDR_DW-1:0]  sdr_dout,
   output logic [sdram_pkg::SDR_BW-1:0]  sdr_den_n
);
   import sdram_pkg::*;

   seq_state_e       state;
   sdram_cmd_e       cmd_q;      // Command on the pins
   logic             cke_q;
   logic [BA_W-1:0]  ba_q;
   logic [ROW_W-1:0] addr_q;
   logic [TIM_W:0]   cnt;        // Shared wait counter, one extra bit for sums
   logic             cnt_done;
   logic [1:0]       ref_cnt;    // Init refreshes issued
   logic [1:0]       wr_sh;      // Write beat slots
   logic [9:0]       rd_sh;      // Read beat slots, covers cas 7
   logic [ROW_W-1:0] mode_word;
   logic [ROW_W-1:0] col_addr;

   assign cnt_done = (cnt == '0);

   // BL field 1 (two beats), sequential, write burst on
   assign mode_word = {5'b0, timing.cas, 1'b0, 3'b001};
   assign col_addr  = {1'b0, 1'b1, 2'b00, beat_addr.col};  // A10 = auto precharge

   // ------------------------------
   // Strobes to the other blocks
   // ------------------------------
   assign refresh_ack = (state == S_IDLE) && refresh_due;
   assign take_req    = (state == S_IDLE) && !refresh_due && req_valid;
   assign wr_beat     = wr_sh[0];
   assign rd_beat     = rd_sh[0];

   // ------------------------------
   // Pin and data outputs
   // ------------------------------
   assign pins = '{cke:  cke_q,
                   cmd:  cmd_q,
                   ba:   ba_q,
                   addr: addr_q,
                   dqm:  wr_beat ? wr_dqm : {SDR_BW{1'b0}}};  // Reads unmasked
   assign sdr_dout  = wr_data;
   assign sdr_den_n = {SDR_BW{!wr_beat}};  // Drive only in beat cycles

   always_ff @(posedge clk) begin
      if (reset) begin
         state     <= S_INIT_WAIT;
         cmd_q     <= NOP;
         cke_q     <= 1'b0;
         ba_q      <= '0;
         addr_q    <= '0;
         cnt       <= '0;
         ref_cnt   <= '0;
         wr_sh     <= '0;
         rd_sh     <= '0;
         init_done <= 1'b0;
      end else begin
         // Defaults: NOP, beats shift out, counter runs down
         cmd_q <= NOP;
         wr_sh <= {1'b0, wr_sh[1]};
         rd_sh <= rd_sh >> 1;
         if (!cnt_done)
            cnt <= cnt - 1'b1;

         case (state)
            S_INIT_WAIT: begin
               if (init_start) begin
                  cke_q <= 1'b1;         // One NOP cycle with cke high
                  cnt   <= '0;
                  state <= S_INIT_PRE;
               end
            end
            S_INIT_PRE: begin
               if (cnt_done) begin
                  cmd_q   <= PRECHARGE;
                  addr_q  <= 12'h400;    // All banks
                  cnt     <= {1'b0, timing.trp} - 1'b1;
                  ref_cnt <= '0;
                  state   <= S_INIT_REF;
               end
            end
            S_INIT_REF: begin
               if (cnt_done) begin
                  cmd_q   <= REFRESH;
                  cnt     <= {1'b0, timing.trcar} - 1'b1;
                  ref_cnt <= ref_cnt + 1'b1;
                  if (ref_cnt == 2'(INIT_REFRESHES - 1))
                     state <= S_INIT_MODE;
               end
            end
            S_INIT_MODE: begin
               if (cnt_done) begin
                  cmd_q  <= LOAD_MODE;
                  ba_q   <= '0;
                  addr_q <= mode_word;
                  cnt    <= (TIM_W+1)'(TMRD - 1);
                  state  <= S_RECOVER;   // Init done after tMRD
               end
            end
            S_IDLE: begin
               if (refresh_due) begin
                  cmd_q <= REFRESH;
                  cnt   <= {1'b0, timing.trcar} - 1'b1;
                  state <= S_REFRESH;
               end else if (req_valid) begin
                  state <= S_ACTIVATE;   // Word path latches this cycle
               end
            end
            S_REFRESH: begin
               if (cnt_done)
                  state <= S_IDLE;
            end
            S_ACTIVATE: begin
               cmd_q  <= ACTIVE;
               ba_q   <= beat_addr.ba;
               addr_q <= beat_addr.row;
               cnt    <= {1'b0, timing.trcd} - 1'b1;
               state  <= S_ACCESS;
            end
            S_ACCESS: begin
               if (cnt_done) begin
                  addr_q <= col_addr;
                  if (req_write) begin
                     cmd_q <= WRITE;
                     wr_sh <= 2'b11;     // Beat 0 with the command, beat 1 next
                     cnt   <= {1'b0, timing.twr} + {1'b0, timing.trp};
                  end else begin
                     cmd_q <= READ;
                     // Data at cas and cas+1, plus the input register
                     rd_sh <= 10'b11 << ({1'b0, timing.cas} + 4'd1);
                     cnt   <= {2'b00, timing.cas} + {1'b0, timing.trp} + 5'd2;
                  end
                  state <= S_RECOVER;
               end
            end
            S_RECOVER: begin
               if (cnt_done) begin
                  init_done <= 1'b1;     // First exit ends init, then stays high
                  state     <= S_IDLE;
               end
            end
            default: state <= S_IDLE;
         endcase
      end
   end

endmodule

// File: source/sdram_ctrl_top.sv
/* SDRAM controller top: one 4M x 16 device behind a 32-bit word port.
   Read data is registered once on clk, so board delay must fit one cycle. */
`timescale 1ns/1ps

module sdram_ctrl_top (
   input  logic                          clk,
   input  logic                          reset,
   input  logic                          app_req,
   input  sdram_pkg::app_req_t           app_req_data,
   output logic                          app_req_ack,
   output logic [sdram_pkg::APP_DW-1:0]  app_rd_data,
   output logic                          app_rd_valid,
   output logic                          sdr_init_done,
   input  sdram_pkg::sdram_timing_t      cfg_timing,
   output sdram_pkg::sdram_pins_t        sdr_pins,
   input  logic [sdram_pkg::SDR_DW-1:0]  sdr_din,
   output logic [sdram_pkg::SDR_DW-1:0]  sdr_dout,
   output logic [sdram_pkg::SDR_BW-1:0]  sdr_den_n
);
   import sdram_pkg::*;

   logic              init_start, refresh_due, refresh_ack;
   logic              req_valid, req_write, take_req;
   logic              wr_beat, rd_beat;
   beat_addr_t        beat_addr;
   logic [SDR_DW-1:0] wr_data;
   logic [SDR_BW-1:0] wr_dqm;
   logic [SDR_DW-1:0] din_q;  // Read data input register

   assign app_req_ack = take_req;  // Ack is the accept cycle

   always_ff @(posedge clk) begin
      din_q <= sdr_din;
   end

   // ------------------------------
   sdram_maint_sched u_maint (
      .clk, .reset, .timing(cfg_timing), .init_done(sdr_init_done),
      .refresh_ack, .init_start, .refresh_due);

   sdram_word_path u_word (
      .clk, .reset, .app_req, .app_req_data, .take_req, .wr_beat, .rd_beat,
      .sdr_din(din_q), .req_valid, .req_write, .beat_addr, .wr_data, .wr_dqm,
      .app_rd_data, .app_rd_valid);

   sdram_cmd_seq u_seq (
      .clk, .reset, .timing(cfg_timing), .init_start, .refresh_due,
      .req_valid, .req_write, .beat_addr, .wr_data, .wr_dqm,
      .refresh_ack, .take_req, .wr_beat, .rd_beat, .init_done(sdr_init_done),
      .pins(sdr_pins), .sdr_dout, .sdr_den_n);

endmodule

// File: source/sdram_maint_sched.sv
/* Power-up wait and periodic refresh request for the command sequencer.
   Refresh interval restarts on each refresh_ack; a late ack stretches it. */
`timescale 1ns/1ps

module sdram_maint_sched (
   input  logic                     clk,
   input  logic                     reset,
   input  sdram_pkg::sdram_timing_t timing,
   input  logic                     init_done,
   input  logic                     refresh_ack,
   output logic                     init_start,
   output logic                     refresh_due
);
   import sdram_pkg::*;

   logic [$clog2(INIT_WAIT)-1:0] wait_cnt;   // Power-up cycle count
   logic                         wait_over;  // Wait already finished
   logic [RFSH_W-1:0]            rfsh_cnt;   // Down counter to next refresh

   // ------------------------------
   // Power-up wait, runs once
   // ------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         wait_cnt   <= '0;
         wait_over  <= 1'b0;
         init_start <= 1'b0;
      end else begin
         init_start <= 1'b0;
         if (!wait_over) begin
            if (wait_cnt == ($clog2(INIT_WAIT))'(INIT_WAIT - 1)) begin
               wait_over  <= 1'b1;
               init_start <= 1'b1;  // Single pulse
            end else begin
               wait_cnt <= wait_cnt + 1'b1;
            end
         end
      end
   end

   // ------------------------------
   // Refresh interval
   // ------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         rfsh_cnt    <= '0;
         refresh_due <= 1'b0;
      end else begin
         if (!init_done || refresh_ack)
            rfsh_cnt <= timing.rfsh;           // Held until init, reload on ack
         else if (rfsh_cnt != '0)
            rfsh_cnt <= rfsh_cnt - 1'b1;
         if (refresh_ack)
            refresh_due <= 1'b0;               // Ack wins over a new expiry
         else if (init_done && rfsh_cnt == '0)
            refresh_due <= 1'b1;
      end
   end

endmodule

// File: source/sdram_pkg.sv
/* Single 4M x 16 SDRAM, 4 banks, 12 row and 8 column bits, one rank.
   Timing fields count clk cycles and must each be at least 1.
   Closed page only, so tRCD + 2 + tWR must cover tRAS of the device. */
package sdram_pkg;

   // ------------------------------
   // Geometry
   // ------------------------------
   localparam int APP_AW = 21;   // Word address: bank 2, row 12, column 7
   localparam int APP_DW = 32;
   localparam int APP_BW = 4;
   localparam int SDR_DW = 16;   // Device data width
   localparam int SDR_BW = 2;    // One DQM per byte lane
   localparam int ROW_W  = 12;
   localparam int COL_W  = 8;
   localparam int BA_W   = 2;

   // ------------------------------
   // Fixed timing
   // ------------------------------
   localparam int INIT_WAIT      = 200;  // Power-up wait with cke low
   localparam int INIT_REFRESHES = 2;
   localparam int TMRD           = 2;    // Mode load to next command
   localparam int RFSH_W         = 12;   // Refresh interval counter
   localparam int TIM_W          = 4;    // Runtime timing fields

   // Command encoding {cs_n, ras_n, cas_n, we_n}
   typedef enum logic [3:0] {
      NOP       = 4'b0111,
      ACTIVE    = 4'b0011,
      READ      = 4'b0101,
      WRITE     = 4'b0100,
      PRECHARGE = 4'b0010,
      REFRESH   = 4'b0001,
      LOAD_MODE = 4'b0000
   } sdram_cmd_e;

   // Sequencer states, init walk first
   typedef enum logic [3:0] {
      S_INIT_WAIT,
      S_INIT_PRE,
      S_INIT_REF,
      S_INIT_MODE,
      S_IDLE,
      S_REFRESH,
      S_ACTIVATE,
      S_ACCESS,
      S_RECOVER
   } seq_state_e;

   typedef struct packed {
      logic [TIM_W-1:0]  trp;    // Precharge to activate
      logic [TIM_W-1:0]  trcd;   // Activate to read/write
      logic [TIM_W-1:0]  trcar;  // Refresh to next command
      logic [TIM_W-1:0]  twr;    // Last write beat to precharge
      logic [2:0]        cas;    // CAS latency
      logic [RFSH_W-1:0] rfsh;   // Cycles between refreshes
   } sdram_timing_t;

   typedef struct packed {
      logic [APP_AW-1:0] addr;
      logic              write;    // 1 = write, 0 = read
      logic [APP_DW-1:0] wdata;
      logic [APP_BW-1:0] wr_en_n;  // Active-low byte enables
   } app_req_t;

   typedef struct packed {
      logic              cke;
      sdram_cmd_e        cmd;
      logic [BA_W-1:0]   ba;
      logic [ROW_W-1:0]  addr;
      logic [SDR_BW-1:0] dqm;
   } sdram_pins_t;

   typedef struct packed {
      logic [BA_W-1:0]  ba;
      logic [ROW_W-1:0] row;
      logic [COL_W-1:0] col;  // Even column, beat 0
   } beat_addr_t;

endpackage

// File: source/sdram_word_path.sv
/* Word side of the controller: one 32-bit word is two 16-bit beats,
   low half first at the even column. One request is held at a time,
   and read data is never back-pressured. */
`timescale 1ns/1ps

module sdram_word_path (
   input  logic                          clk,
   input  logic                          reset,
   input  logic                          app_req,
   input  sdram_pkg::app_req_t           app_req_data,
   input  logic                          take_req,
   input  logic                          wr_beat,
   input  logic                          rd_beat,
   input  logic [sdram_pkg::SDR_DW-1:0]  sdr_din,
   output logic                          req_valid,
   output logic                          req_write,
   output sdram_pkg::beat_addr_t         beat_addr,
   output logic [sdram_pkg::SDR_DW-1:0]  wr_data,
   output logic [sdram_pkg::SDR_BW-1:0]  wr_dqm,
   output logic [sdram_pkg::APP_DW-1:0]  app_rd_data,
   output logic                          app_rd_valid
);
   import sdram_pkg::*;

   app_req_t          req_q;     // Accepted request, payload only
   logic              wr_hi;     // Second write beat selected
   logic              rd_hi;     // Next read beat is the high half
   logic [SDR_DW-1:0] rd_lo_q;   // First read beat

   // Request level goes straight to the sequencer
   assign req_valid = app_req;
   assign req_write = req_q.write;

   // ------------------------------
   // Address split
   // ------------------------------
   // Top bits bank, then row, word column shifted up one for the beat
   assign beat_addr.ba  = req_q.addr[APP_AW-1 -: BA_W];
   assign beat_addr.row = req_q.addr[APP_AW-BA_W-1 -: ROW_W];
   assign beat_addr.col = {req_q.addr[COL_W-2:0], 1'b0};

   // Current write half and its byte masks
   assign wr_data = wr_hi ? req_q.wdata[APP_DW-1:SDR_DW] : req_q.wdata[SDR_DW-1:0];
   assign wr_dqm  = wr_hi ? req_q.wr_en_n[APP_BW-1:SDR_BW] : req_q.wr_en_n[SDR_BW-1:0];

   always_ff @(posedge clk) begin
      if (take_req)
         req_q <= app_req_data;  // Sampled in the ack cycle
   end

   always_ff @(posedge clk) begin
      if (reset)
         wr_hi <= 1'b0;
      else if (take_req)
         wr_hi <= 1'b0;
      else if (wr_beat)
         wr_hi <= 1'b1;          // Advance after beat 0
   end

   // ------------------------------
   // Read repack
   // ------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         rd_hi        <= 1'b0;
         app_rd_valid <= 1'b0;
      end else begin
         app_rd_valid <= rd_beat && rd_hi;  // One cycle after beat 1
         if (rd_beat)
            rd_hi <= !rd_hi;
      end
   end

   always_ff @(posedge clk) begin
      if (rd_beat && !rd_hi)
         rd_lo_q <= sdr_din;
      if (rd_beat && rd_hi)
         app_rd_data <= {sdr_din, rd_lo_q};
   end

endmodule

// File: sources.f
source/sdram_pkg.sv
source/sdram_maint_sched.sv
source/sdram_word_path.sv
source/sdram_cmd_seq.sv
source/sdram_ctrl_top.sv
tb/sdram_model.sv
tb/sdram_ctrl_asserts.sv
tb/sdram_tb.sv

// File: tb/sdram_ctrl_asserts.sv
/* Protocol timing checks for the command sequencer, bound in below.
   Spacing counters saturate at 255 cycles. */
`timescale 1ns/1ps

module sdram_ctrl_asserts (
   input logic                          clk,
   input logic                          reset,
   input sdram_pkg::sdram_timing_t      timing,
   input sdram_pkg::sdram_pins_t        pins,
   input logic [sdram_pkg::SDR_BW-1:0]  sdr_den_n
);
   import sdram_pkg::*;

   int unsigned fail_cnt = 0;   // Read by the testbench at the end
   logic [7:0]  since_act;      // Cycles since the last ACTIVE
   logic [7:0]  since_ref;      // Cycles since the last REFRESH

   always_ff @(posedge clk) begin
      if (reset) begin
         since_act <= '1;
         since_ref <= '1;
      end else begin
         if (pins.cmd == ACTIVE)
            since_act <= 8'd1;
         else if (since_act != '1)
            since_act <= since_act + 1'b1;
         if (pins.cmd == REFRESH)
            since_ref <= 8'd1;
         else if (since_ref != '1)
            since_ref <= since_ref + 1'b1;
      end
   end

   act_to_rw: assert property (@(posedge clk) disable iff (reset)
      (pins.cmd == READ || pins.cmd == WRITE) |-> since_act >= timing.trcd)
      else begin
         $error("READ or WRITE issued earlier than tRCD after ACTIVE");
         fail_cnt++;
      end

   ref_to_cmd: assert property (@(posedge clk) disable iff (reset)
      (pins.cmd != NOP) |-> since_ref >= timing.trcar)
      else begin
         $error("Command issued earlier than tRC after REFRESH");
         fail_cnt++;
      end

   // Write beats are the WRITE cycle and the one after it
   den_in_beat: assert property (@(posedge clk) disable iff (reset)
      (sdr_den_n != '1) |-> (pins.cmd == WRITE || $past(pins.cmd == WRITE)))
      else begin
         $error("Data bus driven outside a write beat");
         fail_cnt++;
      end

endmodule

bind sdram_cmd_seq sdram_ctrl_asserts u_asserts (
   .clk, .reset, .timing, .pins, .sdr_den_n);

// File: tb/sdram_model.sv
/* Behavioral 4M x 16 SDRAM, one burst of two beats per READ or WRITE.
   CAS latency 2 to 7 only. Unwritten cells read a fill from their address. */
`timescale 1ns/1ps

module sdram_model (
   input  logic                          clk,
   input  sdram_pkg::sdram_pins_t        pins,
   input  logic [2:0]                    cas,
   input  logic [sdram_pkg::SDR_DW-1:0]  dq_in,
   input  logic [sdram_pkg::SDR_BW-1:0]  den_n,
   output logic [sdram_pkg::SDR_DW-1:0]  dq_out
);
   import sdram_pkg::*;

   typedef logic [BA_W+ROW_W+COL_W-1:0] cell_t;  // {bank, row, column}

   logic [SDR_DW-1:0] mem [cell_t];       // Sparse storage
   logic [ROW_W-1:0]  open_row [1<<BA_W];
   logic [SDR_DW-1:0] rd_pipe [8];        // Read data on its way out
   logic              wr_next;            // Second write beat due
   cell_t             wr_cell;

   function automatic logic [SDR_DW-1:0] read_half(input cell_t c);
      if (mem.exists(c))
         return mem[c];
      return c[15:0] ^ {c[21:16], 10'h155};  // Fill uses every address bit
   endfunction

   // Byte lanes with DQM high keep their old contents
   task automatic store_half(input cell_t c, input logic [SDR_DW-1:0] d,
                             input logic [SDR_BW-1:0] dqm);
      logic [SDR_DW-1:0] old;
      old    = read_half(c);
      mem[c] = {dqm[1] ? old[15:8] : d[15:8], dqm[0] ? old[7:0] : d[7:0]};
   endtask

   initial begin
      dq_out  = '0;
      wr_next = 1'b0;
      wr_cell = '0;
      for (int i = 0; i < 8; i++)
         rd_pipe[i] = '0;
   end

   always @(posedge clk) begin
      cell_t c;
      c = {pins.ba, open_row[pins.ba], pins.addr[COL_W-1:0]};
      // ------------------------------
      // Read pipeline, one slot per cycle
      dq_out <= rd_pipe[0];
      for (int i = 0; i < 7; i++)
         rd_pipe[i] <= rd_pipe[i+1];
      rd_pipe[7] <= '0;
      wr_next    <= 1'b0;
      if (wr_next && den_n == '0)
         store_half(wr_cell, dq_in, pins.dqm);   // Beat 1
      if (pins.cke) begin
         case (pins.cmd)
            ACTIVE: open_row[pins.ba] = pins.addr;
            READ: begin
               rd_pipe[cas-2] <= read_half(c);      // Valid at edge cas after READ
               rd_pipe[cas-1] <= read_half(c + 1'b1);
            end
            WRITE: begin
               if (den_n == '0)
                  store_half(c, dq_in, pins.dqm);  // Beat 0 rides with the command
               wr_next <= 1'b1;
               wr_cell <= c + 1'b1;
            end
            default: ;
         endcase
      end
   end

endmodule

// File: tb/sdram_tb.sv
/* Controller testbench: init order, word writes and reads, byte masks,
   random traffic against a shadow memory, and refresh spacing.
   Reads only touch words already written in full. */
`timescale 1ns/1ps

module sdram_tb;
   import sdram_pkg::*;

   localparam int POOL     = 16;                   // Random test address pool
   localparam int N_OPS    = 2 + 3 + POOL + 64;
   localparam int TIMEOUT  = INIT_WAIT + 100 + N_OPS * 40;
   localparam int RFSH_GAP = 300 + 40;             // rfsh plus slack

   logic clk, reset, app_req, app_req_ack, app_rd_valid, sdr_init_done;
   app_req_t          app_req_data;
   logic [APP_DW-1:0] app_rd_data;
   sdram_timing_t     cfg_timing;
   sdram_pins_t       sdr_pins;
   logic [SDR_DW-1:0] sdr_din, sdr_dout;
   logic [SDR_BW-1:0] sdr_den_n;

   integer            seed = 32'h3a27_7bd2;
   int                errors = 0;
   int                cycle = 0;
   string             test_name = "init";
   logic [APP_DW-1:0] shadow [logic [APP_AW-1:0]];  // Expected memory contents
   logic [APP_DW-1:0] expect_q [$];                  // Reads in flight, oldest first
   logic [APP_AW-1:0] pool [POOL];
   int                init_step = 0;
   int                last_ref = -1;
   int                n_ref = 0;

   sdram_ctrl_top dut (.*);

   sdram_model u_mem (.clk, .pins(sdr_pins), .cas(cfg_timing.cas), .dq_in(sdr_dout),
                      .den_n(sdr_den_n), .dq_out(sdr_din));

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // ------------------------------
   // Reference model and reporting
   // ------------------------------
   // Byte kept where its active-low enable is high
   function automatic logic [APP_DW-1:0] merge_bytes(input logic [APP_DW-1:0] old_w,
         input logic [APP_DW-1:0] new_w, input logic [APP_BW-1:0] en_n);
      logic [APP_DW-1:0] res;
      for (int b = 0; b < APP_BW; b++)
         res[8*b +: 8] = en_n[b] ? old_w[8*b +: 8] : new_w[8*b +: 8];
      return res;
   endfunction

   task automatic report_mismatch(input string what, input logic [31:0] exp_v,
                                  input logic [31:0] act_v);
      $display("** Error [%s] %s: expected %h, actual %h", test_name, what, exp_v, act_v);
      errors++;
   endtask

   task automatic report_problem(input string msg);
      $display("Problem in %s test: %s", test_name, msg);
      errors++;
   endtask

   // ------------------------------
   // Request side
   // ------------------------------
   task automatic issue(input app_req_t r);
      @(posedge clk);
      app_req      <= 1'b1;
      app_req_data <= r;
      @(negedge clk);
      while (!app_req_ack)
         @(negedge clk);
      if (!r.write)
         expect_q.push_back(shadow[r.addr]);  // Order of acceptance
      @(posedge clk);
      app_req <= 1'b0;
   endtask

   task automatic write_word(input logic [APP_AW-1:0] a, input logic [APP_DW-1:0] d,
                             input logic [APP_BW-1:0] en_n);
      issue('{addr: a, write: 1'b1, wdata: d, wr_en_n: en_n});
      shadow[a] = merge_bytes(shadow.exists(a) ? shadow[a] : '0, d, en_n);
   endtask

   task automatic read_word(input logic [APP_AW-1:0] a);
      issue('{addr: a, write: 1'b0, wdata: '0, wr_en_n: '1});
   endtask

   task automatic drain_reads();
      while (expect_q.size() != 0)
         @(negedge clk);
   endtask

   // ------------------------------
   // Compare and monitor processes
   // ------------------------------
   always @(negedge clk) begin : compare
      logic [APP_DW-1:0] exp_word;
      if (!reset && app_rd_valid) begin
         assert (expect_q.size() != 0)
         else report_problem("read data returned with no read outstanding");
         if (expect_q.size() != 0) begin
            exp_word = expect_q.pop_front();
            assert (app_rd_data === exp_word)
            else report_mismatch("read data", exp_word, app_rd_data);
         end
      end
   end

   // Init commands in order, then refresh spacing
   task automatic check_init_cmd();
      sdram_cmd_e c;
      c = sdr_pins.cmd;
      if (c != NOP) begin
         case (init_step)
            0: begin
               assert (c == PRECHARGE) else report_mismatch("command 0", PRECHARGE, c);
               assert (sdr_pins.addr[10]) else report_problem("precharge without A10");
            end
            1, 2: assert (c == REFRESH) else report_mismatch("init refresh", REFRESH, c);
            3: begin
               assert (c == LOAD_MODE) else report_mismatch("command 3", LOAD_MODE, c);
               // BL field 1, sequential, CAS in bits 6:4, burst writes
               assert (sdr_pins.addr == ((12'(cfg_timing.cas) << 4) | 12'h001))
               else report_mismatch("mode word", (12'(cfg_timing.cas) << 4) | 12'h001,
                                    sdr_pins.addr);
            end
            default: report_problem("extra command before init done");
         endcase
         init_step++;
      end
   endtask

   always @(negedge clk) begin
      if (!reset) begin
         if (!sdr_init_done) begin
            check_init_cmd();
         end else begin
            if (last_ref < 0)
               last_ref = cycle;                // Interval starts at init done
            if (sdr_pins.cmd == REFRESH) begin
               assert (cycle - last_ref <= RFSH_GAP)
               else report_problem($sformatf("refresh gap of %0d cycles",
                                             cycle - last_ref));
               last_ref = cycle;
               n_ref++;
            end
         end
      end
   end

   always @(posedge clk) begin
      cycle++;
      if (cycle >= TIMEOUT) begin
         $display("Timeout: run did not finish within %0d cycles", TIMEOUT);
         $display("Closing counts: %0d testbench errors, %0d assertion failures",
                  errors, dut.u_seq.u_asserts.fail_cnt);
         $display("** FAIL **");
         $finish;
      end
   end

   // ------------------------------
   // Stimulus
   // ------------------------------
   initial begin
      logic [APP_AW-1:0] a;
      logic [APP_DW-1:0] d;
      int                total;
      reset        <= 1'b1;
      app_req      <= 1'b0;
      app_req_data <= '0;
      cfg_timing   <= '{trp: 4'd3, trcd: 4'd3, trcar: 4'd7, twr: 4'd2, cas: 3'd3,
                        rfsh: 12'd300};
      repeat (16) @(posedge clk);
      reset <= 1'b0;
      while (!sdr_init_done)
         @(negedge clk);
      assert (init_step == 4) else report_problem("init sequence incomplete");

      test_name = "write_read";
      a = APP_AW'($random(seed));
      d = $random(seed);
      write_word(a, d, 4'b0000);
      read_word(a);
      drain_reads();

      test_name = "byte_mask";
      a = APP_AW'($random(seed));
      write_word(a, 32'h1122_3344, 4'b0000);
      write_word(a, 32'haabb_ccdd, 4'b0101);   // Bytes 0 and 2 stay
      read_word(a);
      drain_reads();

      test_name = "random";
      for (int i = 0; i < POOL; i++) begin
         pool[i] = APP_AW'($random(seed));
         write_word(pool[i], $random(seed), 4'b0000);
      end
      for (int i = 0; i < 64; i++) begin
         a = pool[$unsigned($random(seed)) % POOL];
         if ($random(seed) & 1)
            write_word(a, $random(seed), 4'($random(seed)));
         else
            read_word(a);
      end
      drain_reads();

      test_name = "refresh";
      repeat (20) @(negedge clk);
      assert (n_ref >= 2) else report_problem("too few refreshes after init");
      assert (cycle - last_ref <= RFSH_GAP) else report_problem("refresh stopped");

      total = errors + int'(dut.u_seq.u_asserts.fail_cnt);
      $display("Closing counts: %0d testbench errors, %0d assertion failures",
               errors, dut.u_seq.u_asserts.fail_cnt);
      if (total == 0)
         $display("** PASS **");
      else
         $display("** FAIL **");
      $finish;
   end

endmodule
